// ==== delay_subsys.f ====
+incdir+hdl
hdl/up_bus_pkg.sv
hdl/delay_pkg.sv
hdl/delay_calib_timer.sv
hdl/delay_lock_fsm.sv
hdl/delay_tap_line.sv
hdl/up_delay_cntrl.sv
hdl/delay_subsys.sv
tb/tb_delay_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the delay subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir

# packages have no timescale of their own, default matches the modules
verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_delay_subsys \
  -f delay_subsys.f \
  -o tb_delay_subsys

./obj_dir/tb_delay_subsys | tee "$LOG"

if grep -q "^Test OK$" "$LOG"; then
  echo "simulation passed"
else
  echo "simulation failed, see $LOG"
  exit 1
fi

// ==== tb/tb_delay_subsys.sv ====
// ****************************************
// testbench for the IO delay subsystem
// ****************************************

`timescale 1ns/1ps

`include "delay_cfg.svh"

module tb_delay_subsys;

  import up_bus_pkg::*;
  import delay_pkg::*;

  localparam int TABLE_LEN   = 14;
  localparam int CYCLE_LIMIT = TABLE_LEN * 8 + `DELAY_CALIB_CYCLES + 400;
  // reads allowed while waiting for lock
  localparam int POLL_LIMIT  = `DELAY_CALIB_CYCLES + 40;

  logic                     up_clk = 1'b0;
  logic                     delay_clk = 1'b0;
  logic                     up_rstn;
  logic                     up_wreq;
  up_addr_t                 up_waddr;
  up_data_t                 up_wdata;
  logic                     up_wack;
  logic                     up_rreq;
  up_addr_t                 up_raddr;
  up_data_t                 up_rdata;
  logic                     up_rack;
  logic [`DELAY_LANES-1:0]  data_in;
  logic [`DELAY_LANES-1:0]  data_out;
  logic                     delay_locked;

  // run bookkeeping
  int      cycles = 0;
  int      errors;
  int      test_errs;
  int      tests;
  int      failed;
  integer  seed;

  // stimulus table with one bus access per entry
  bit        tab_wr    [TABLE_LEN];
  up_addr_t  tab_addr  [TABLE_LEN];
  up_data_t  tab_wdata [TABLE_LEN];
  up_data_t  tab_rdata [TABLE_LEN];
  bit        tab_ack   [TABLE_LEN];
  string     tab_name  [TABLE_LEN];

  delay_subsys i_delay_subsys (
    .up_clk       (up_clk),
    .up_rstn      (up_rstn),
    .up_wreq      (up_wreq),
    .up_waddr     (up_waddr),
    .up_wdata     (up_wdata),
    .up_wack      (up_wack),
    .up_rreq      (up_rreq),
    .up_raddr     (up_raddr),
    .up_rdata     (up_rdata),
    .up_rack      (up_rack),
    .delay_clk    (delay_clk),
    .data_in      (data_in),
    .data_out     (data_out),
    .delay_locked (delay_locked)
  );

  // ****************************************
  // clocks and watchdog
  // ****************************************

  always #2 up_clk = ~up_clk;

  // same period but 1 ns behind up_clk
  always @(up_clk) begin
    #1 delay_clk = up_clk;
  end

  always @(posedge up_clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("run stopped, no finish after %0d up_clk cycles", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  // ****************************************
  // helpers
  // ****************************************

  function automatic up_addr_t lane_addr(input logic [5:0] blk, input int lane);
    return {blk, 8'(lane)};
  endfunction

  task automatic add_entry(input int idx, input bit wr, input logic [5:0] blk, input int lane,
                           input up_data_t wdata, input up_data_t rdata, input bit ack,
                           input string name);
    tab_wr[idx]    = wr;
    tab_addr[idx]  = lane_addr(blk, lane);
    tab_wdata[idx] = wdata;
    tab_rdata[idx] = rdata;
    tab_ack[idx]   = ack;
    tab_name[idx]  = name;
  endtask

  task automatic show_mismatch(input string name, input up_data_t exp, input up_data_t act);
    $display("ERR %s expected %h actual %h", name, exp, act);
    errors++;
  endtask

  task automatic report_problem(input string name, input string what);
    $display("%s: %s", name, what);
    errors++;
  endtask

  task automatic start_test();
    test_errs = errors;
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == test_errs) begin
      $display("%-20s pass", name);
    end else begin
      failed++;
      $display("%-20s fail", name);
    end
  endtask

  // bus tasks start and end on a falling up_clk edge
  task automatic write_reg(input string name, input up_addr_t addr, input up_data_t data);
    up_wreq  = 1'b1;
    up_waddr = addr;
    up_wdata = data;
    @(negedge up_clk);
    up_wreq = 1'b0;
    if (up_wack !== 1'b1) show_mismatch(name, 32'd1, 32'(up_wack));
    @(negedge up_clk);
    if (up_wack !== 1'b0) show_mismatch(name, 32'd0, 32'(up_wack));
  endtask

  task automatic read_reg(input string name, input up_addr_t addr, output up_data_t data);
    up_rreq  = 1'b1;
    up_raddr = addr;
    @(negedge up_clk);
    up_rreq = 1'b0;
    data    = up_rdata;
    if (up_rack !== 1'b1) show_mismatch(name, 32'd1, 32'(up_rack));
    @(negedge up_clk);
    // ack lasts one cycle and read data drops back to zero
    if (up_rack !== 1'b0) show_mismatch(name, 32'd0, 32'(up_rack));
    if (up_rdata !== '0) show_mismatch(name, '0, up_rdata);
  endtask

  task automatic expect_no_ack(input string name, input bit wr, input up_addr_t addr,
                               input up_data_t data);
    up_wreq  = wr;
    up_rreq  = !wr;
    up_waddr = addr;
    up_raddr = addr;
    up_wdata = data;
    repeat (4) begin
      @(negedge up_clk);
      up_wreq = 1'b0;
      up_rreq = 1'b0;
      if (up_wack !== 1'b0 || up_rack !== 1'b0) begin
        report_problem(name, "acknowledge seen for a foreign block address");
      end
    end
  endtask

  // single pulse in and expected back after tap+1 delay_clk cycles
  task automatic check_pulse(input string name, input int lane, input tap_t tap);
    logic [`DELAY_LANES-1:0] exp_out;
    data_in[lane] = 1'b1;
    for (int i = 1; i <= DELAY_LINE_DEPTH + 2; i++) begin
      @(negedge up_clk);
      data_in[lane] = 1'b0;
      exp_out = (i == int'(tap) + 1) ? (`DELAY_LANES'(1) << lane) : '0;
      if (data_out !== exp_out) show_mismatch(name, 32'(exp_out), 32'(data_out));
    end
  endtask

  // ****************************************
  // test sequence
  // ****************************************

  initial begin
    up_data_t  rd;
    int        lane;
    int        polls;
    tap_t      tap;
    string     name;

    seed     = 32'hd000_f3a6;
    up_rstn  = 1'b0;
    up_wreq  = 1'b0;
    up_waddr = '0;
    up_wdata = '0;
    // decoded read held through reset
    up_rreq  = 1'b1;
    up_raddr = lane_addr(`DELAY_BASE_ADDR, 0);
    data_in  = '0;

    // readback keeps the low 5 bits of the written word
    add_entry(0, 1'b1, `DELAY_BASE_ADDR, 0, 32'h0000_0007, '0, 1'b1, "wr_lane0");
    add_entry(1, 1'b0, `DELAY_BASE_ADDR, 0, '0, 32'h0000_0007, 1'b1, "rd_lane0");
    add_entry(2, 1'b1, `DELAY_BASE_ADDR, 5, 32'hdead_beef, '0, 1'b1, "wr_lane5");
    add_entry(3, 1'b0, `DELAY_BASE_ADDR, 5, '0, 32'h0000_000f, 1'b1, "rd_lane5");
    add_entry(4, 1'b1, `DELAY_BASE_ADDR, 2, 32'h0000_00ff, '0, 1'b1, "wr_lane2");
    add_entry(5, 1'b0, `DELAY_BASE_ADDR, 2, '0, 32'h0000_001f, 1'b1, "rd_lane2");
    add_entry(6, 1'b1, `DELAY_BASE_ADDR, 7, 32'h1234_5660, '0, 1'b1, "wr_lane7");
    add_entry(7, 1'b0, `DELAY_BASE_ADDR, 7, '0, 32'h0000_0000, 1'b1, "rd_lane7");
    // lane past the end is acked but reads zero
    add_entry(8, 1'b1, `DELAY_BASE_ADDR, 9, 32'h0000_0015, '0, 1'b1, "wr_lane9");
    add_entry(9, 1'b0, `DELAY_BASE_ADDR, 9, '0, 32'h0000_0000, 1'b1, "rd_lane9");
    // foreign block must not touch lane 2
    add_entry(10, 1'b1, 6'h05, 2, 32'h0000_0003, '0, 1'b0, "wr_other_blk");
    add_entry(11, 1'b0, `DELAY_BASE_ADDR, 2, '0, 32'h0000_001f, 1'b1, "rd_lane2_kept");
    add_entry(12, 1'b0, 6'h05, 2, '0, '0, 1'b0, "rd_other_blk");
    add_entry(13, 1'b0, `DELAY_BASE_ADDR, 3, '0, 32'h0000_000c, 1'b1, "rd_lane3_init");

    start_test();
    for (int i = 0; i < 16; i++) begin
      @(negedge up_clk);
      if (up_rack !== 1'b0) show_mismatch("reset_idle", 32'd0, 32'(up_rack));
      // delay domain reset lands a few clocks late
      if (i >= 4 && delay_locked !== 1'b0) begin
        show_mismatch("reset_idle", 32'd0, 32'(delay_locked));
      end
    end
    up_rreq = 1'b0;
    up_rstn = 1'b1;
    end_test("reset_idle");

    start_test();
    read_reg("unlocked_read", lane_addr(`DELAY_BASE_ADDR, 0), rd);
    if (rd !== 32'hffff_ffff) show_mismatch("unlocked_read", 32'hffff_ffff, rd);
    polls = 0;
    while (rd === UP_RDATA_UNLOCKED && polls < POLL_LIMIT) begin
      read_reg("lock_poll", lane_addr(`DELAY_BASE_ADDR, 0), rd);
      polls++;
    end
    if (rd === UP_RDATA_UNLOCKED) begin
      report_problem("lock_poll", "reads never left the unlocked value");
    end
    if (delay_locked !== 1'b1) show_mismatch("lock_poll", 32'd1, 32'(delay_locked));
    end_test("unlocked_read");

    start_test();
    for (int n = 0; n < `DELAY_LANES; n++) begin
      read_reg("init_taps", lane_addr(`DELAY_BASE_ADDR, n), rd);
      if (rd !== up_data_t'(`DELAY_INIT_TAP)) begin
        show_mismatch("init_taps", up_data_t'(`DELAY_INIT_TAP), rd);
      end
    end
    end_test("init_taps");

    for (int i = 0; i < TABLE_LEN; i++) begin
      start_test();
      if (!tab_ack[i]) begin
        expect_no_ack(tab_name[i], tab_wr[i], tab_addr[i], tab_wdata[i]);
      end else if (tab_wr[i]) begin
        write_reg(tab_name[i], tab_addr[i], tab_wdata[i]);
      end else begin
        read_reg(tab_name[i], tab_addr[i], rd);
        if (rd !== tab_rdata[i]) show_mismatch(tab_name[i], tab_rdata[i], rd);
      end
      end_test(tab_name[i]);
    end

    // random lane and tap then one pulse through the line
    for (int k = 0; k < 4; k++) begin
      lane = $unsigned($random(seed)) % `DELAY_LANES;
      tap  = tap_t'($random(seed));
      name = $sformatf("pulse_l%0d_t%0d", lane, tap);
      start_test();
      write_reg(name, lane_addr(`DELAY_BASE_ADDR, lane), up_data_t'(tap));
      @(negedge up_clk);
      check_pulse(name, lane, tap);
      end_test(name);
    end

    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== hdl/delay_subsys.sv ====
// *************************************
// IO delay control subsystem top level
// *************************************

`timescale 1ns/1ps

`include "delay_cfg.svh"

module delay_subsys (
  input  logic                     up_clk,
  input  logic                     up_rstn,

  // processor bus
  input  logic                     up_wreq,
  input  up_bus_pkg::up_addr_t     up_waddr,
  input  up_bus_pkg::up_data_t     up_wdata,
  output logic                     up_wack,
  input  logic                     up_rreq,
  input  up_bus_pkg::up_addr_t     up_raddr,
  output up_bus_pkg::up_data_t     up_rdata,
  output logic                     up_rack,

  // delay domain
  input  logic                     delay_clk,
  input  logic [`DELAY_LANES-1:0]  data_in,
  output logic [`DELAY_LANES-1:0]  data_out,
  output logic                     delay_locked
);

  // register block to delay lines
  logic [`DELAY_LANES-1:0]                   up_dld;
  logic [`DELAY_LANES*`DELAY_TAP_WIDTH-1:0]  up_dwdata;
  logic [`DELAY_LANES*`DELAY_TAP_WIDTH-1:0]  up_drdata;

  // reset and lock handshake
  logic                                      up_preset;
  logic                                      delay_rst;
  logic                                      calib_start;
  logic                                      calib_done;

  up_delay_cntrl i_up_delay_cntrl (
    .up_clk       (up_clk),
    .up_rstn      (up_rstn),
    .up_wreq      (up_wreq),
    .up_waddr     (up_waddr),
    .up_wdata     (up_wdata),
    .up_wack      (up_wack),
    .up_rreq      (up_rreq),
    .up_raddr     (up_raddr),
    .up_rdata     (up_rdata),
    .up_rack      (up_rack),
    .delay_locked (delay_locked),
    .up_preset    (up_preset),
    .up_dld       (up_dld),
    .up_dwdata    (up_dwdata),
    .up_drdata    (up_drdata)
  );

  delay_lock_fsm i_delay_lock_fsm (
    .delay_clk    (delay_clk),
    .up_preset    (up_preset),
    .delay_rst    (delay_rst),
    .calib_start  (calib_start),
    .calib_done   (calib_done),
    .delay_locked (delay_locked)
  );

  delay_calib_timer i_delay_calib_timer (
    .delay_clk    (delay_clk),
    .delay_rst    (delay_rst),
    .calib_start  (calib_start),
    .calib_done   (calib_done)
  );

  delay_tap_line i_delay_tap_line (
    .up_clk       (up_clk),
    .up_rstn      (up_rstn),
    .up_dld       (up_dld),
    .up_dwdata    (up_dwdata),
    .up_drdata    (up_drdata),
    .delay_clk    (delay_clk),
    .delay_rst    (delay_rst),
    .data_in      (data_in),
    .data_out     (data_out)
  );

endmodule

// ==== hdl/up_delay_cntrl.sv ====
// *************************************
// delay tap register block, processor side
// handles tap writes, readback and lock
// *************************************

`timescale 1ns/1ps

`include "delay_cfg.svh"

module up_delay_cntrl (
  input  logic                                        up_clk,
  input  logic                                        up_rstn,

  // processor bus
  input  logic                                        up_wreq,
  input  up_bus_pkg::up_addr_t                        up_waddr,
  input  up_bus_pkg::up_data_t                        up_wdata,
  output logic                                        up_wack,
  input  logic                                        up_rreq,
  input  up_bus_pkg::up_addr_t                        up_raddr,
  output up_bus_pkg::up_data_t                        up_rdata,
  output logic                                        up_rack,

  // lock controller
  input  logic                                        delay_locked,
  output logic                                        up_preset,

  // delay lines
  output logic [`DELAY_LANES-1:0]                     up_dld,
  output logic [`DELAY_LANES*`DELAY_TAP_WIDTH-1:0]    up_dwdata,
  input  logic [`DELAY_LANES*`DELAY_TAP_WIDTH-1:0]    up_drdata
);

  import up_bus_pkg::*;
  import delay_pkg::*;

  // decoded requests
  logic                     up_wreq_s;
  logic                     up_rreq_s;

  // per-lane write strobes and selected read tap
  logic [`DELAY_LANES-1:0]  up_dld_s;
  tap_t                     up_rtap_s;

  // lock synchronizer chain
  logic                     up_dlocked_m1;
  logic                     up_dlocked_m2;
  logic                     up_dlocked_m3;
  logic                     up_dlocked;

  // one-cycle strobe on lock's rising edge
  logic                     up_dinit_s;

  // *************************************
  // address decode
  // *************************************

  // only our block select gets an answer
  assign up_wreq_s = up_wreq && (up_waddr[UP_BLK_HI:UP_BLK_LO] == `DELAY_BASE_ADDR);
  assign up_rreq_s = up_rreq && (up_raddr[UP_BLK_HI:UP_BLK_LO] == `DELAY_BASE_ADDR);

  // lane strobes from the write address
  always_comb begin
    up_dld_s = '0;
    for (int n = 0; n < `DELAY_LANES; n++) begin
      if (up_waddr[UP_LANE_HI:UP_LANE_LO] == UP_LANE_W'(n)) begin
        up_dld_s[n] = up_wreq_s;
      end
    end
  end

  // read tap by lane
  // lanes past the end fall through as zero
  always_comb begin
    up_rtap_s = '0;
    for (int n = 0; n < `DELAY_LANES; n++) begin
      if (up_raddr[UP_LANE_HI:UP_LANE_LO] == UP_LANE_W'(n)) begin
        up_rtap_s = up_drdata[n*`DELAY_TAP_WIDTH +: `DELAY_TAP_WIDTH];
      end
    end
  end

  // *************************************
  // acknowledges, read data, lock sync
  // *************************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_preset     <= 1'b1;
      up_wack       <= 1'b0;
      up_rack       <= 1'b0;
      up_rdata      <= '0;
      up_dlocked_m1 <= 1'b0;
      up_dlocked_m2 <= 1'b0;
      up_dlocked_m3 <= 1'b0;
      up_dlocked    <= 1'b0;
    end else begin
      // drops on the first clock out of reset
      up_preset <= 1'b0;
      up_wack   <= up_wreq_s;
      up_rack   <= up_rreq_s;
      if (up_rreq_s) begin
        if (!up_dlocked) begin
          up_rdata <= UP_RDATA_UNLOCKED;
        end else begin
          up_rdata <= up_data_t'(up_rtap_s);
        end
      end else begin
        up_rdata <= '0;
      end
      // delay_locked comes from the delay_clk domain
      up_dlocked_m1 <= delay_locked;
      up_dlocked_m2 <= up_dlocked_m1;
      up_dlocked_m3 <= up_dlocked_m2;
      up_dlocked    <= up_dlocked_m3;
    end
  end

  // *************************************
  // tap load to the delay lines
  // *************************************

  // edge seen between second and third sync stage
  assign up_dinit_s = up_dlocked_m2 & ~up_dlocked_m3;

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_dld <= '0;
    end else if (up_dinit_s) begin
      // initial load hits every lane and wins over a write
      up_dld <= '1;
    end else begin
      up_dld <= up_dld_s;
    end
  end

  // tap data, strobes pick the lanes that take it
  always_ff @(posedge up_clk) begin
    if (up_dinit_s) begin
      up_dwdata <= {`DELAY_LANES{tap_t'(`DELAY_INIT_TAP)}};
    end else if (up_wreq_s) begin
      up_dwdata <= {`DELAY_LANES{tap_t'(up_wdata[`DELAY_TAP_WIDTH-1:0])}};
    end
  end

endmodule

// ==== hdl/delay_tap_line.sv ====
// *************************************
// per-lane tap registers and delay lines
// *************************************

`timescale 1ns/1ps

`include "delay_cfg.svh"

module delay_tap_line (
  // processor side tap access
  input  logic                                      up_clk,
  input  logic                                      up_rstn,
  input  logic [`DELAY_LANES-1:0]                   up_dld,
  input  logic [`DELAY_LANES*`DELAY_TAP_WIDTH-1:0]  up_dwdata,
  output logic [`DELAY_LANES*`DELAY_TAP_WIDTH-1:0]  up_drdata,

  // lane data in the delay domain
  input  logic                                      delay_clk,
  input  logic                                      delay_rst,
  input  logic [`DELAY_LANES-1:0]                   data_in,
  output logic [`DELAY_LANES-1:0]                   data_out
);

  import delay_pkg::*;

  genvar n;

  generate
    for (n = 0; n < `DELAY_LANES; n++) begin : g_lane

      // tap held in the up_clk domain
      tap_t                         tap_q;

      // shift register, bit 0 is the newest sample
      logic [DELAY_LINE_DEPTH-1:0]  line_q;

      always_ff @(posedge up_clk) begin
        if (!up_rstn) begin
          tap_q <= '0;
        end else if (up_dld[n]) begin
          tap_q <= up_dwdata[n*`DELAY_TAP_WIDTH +: `DELAY_TAP_WIDTH];
        end
      end

      // readback shows what is really in effect
      assign up_drdata[n*`DELAY_TAP_WIDTH +: `DELAY_TAP_WIDTH] = tap_q;

      always_ff @(posedge delay_clk) begin
        if (delay_rst) begin
          line_q <= '0;
        end else begin
          line_q <= {line_q[DELAY_LINE_DEPTH-2:0], data_in[n]};
        end
      end

      // tap 0 picks the first stage, one cycle of delay
      // tap is quasi-static, only changed while the lane is idle
      assign data_out[n] = line_q[tap_q];

    end
  endgenerate

endmodule

// ==== hdl/delay_lock_fsm.sv ====
// *************************************
// delay controller reset and lock FSM
// *************************************

`timescale 1ns/1ps

module delay_lock_fsm (
  input  logic  delay_clk,

  // reset request from the processor side
  input  logic  up_preset,
  output logic  delay_rst,

  // calibration timer
  output logic  calib_start,
  input  logic  calib_done,

  output logic  delay_locked
);

  import delay_pkg::*;

  // reset synchronizer first stage
  logic         delay_rst_m1;

  lock_state_t  state;

  // *************************************
  // reset synchronizer
  // *************************************

  // up_preset crosses from up_clk, two flops
  always_ff @(posedge delay_clk) begin
    delay_rst_m1 <= up_preset;
    delay_rst    <= delay_rst_m1;
  end

  // *************************************
  // lock state machine
  // *************************************

  always_ff @(posedge delay_clk) begin
    if (delay_rst) begin
      state        <= RESET;
      calib_start  <= 1'b0;
      delay_locked <= 1'b0;
    end else begin
      // start is a single-cycle strobe
      calib_start <= 1'b0;
      case (state)
        RESET: begin
          // reset released, kick the timer
          state       <= CALIB;
          calib_start <= 1'b1;
        end
        CALIB: begin
          if (calib_done) begin
            state        <= LOCKED;
            delay_locked <= 1'b1;
          end
        end
        LOCKED: begin
          // stay until the next reset
          delay_locked <= 1'b1;
        end
        default: begin
          state <= RESET;
        end
      endcase
    end
  end

endmodule

// ==== hdl/delay_calib_timer.sv ====
// *************************************
// calibration cycle timer
// *************************************

`timescale 1ns/1ps

`include "delay_cfg.svh"

module delay_calib_timer (
  input  logic  delay_clk,
  input  logic  delay_rst,
  input  logic  calib_start,
  output logic  calib_done
);

  localparam int CNT_W = $clog2(`DELAY_CALIB_CYCLES + 1);

  logic [CNT_W-1:0]  count;
  logic              running;

  // count = cycles since start, done raised on the last one
  always_ff @(posedge delay_clk) begin
    if (delay_rst) begin
      count      <= '0;
      running    <= 1'b0;
      calib_done <= 1'b0;
    end else if (calib_start) begin
      count   <= CNT_W'(1);
      running <= 1'b1;
    end else if (running) begin
      count <= count + 1'b1;
      if (count == CNT_W'(`DELAY_CALIB_CYCLES - 1)) begin
        running    <= 1'b0;
        calib_done <= 1'b1;
      end
    end
  end

endmodule

// ==== hdl/delay_pkg.sv ====
// *************************************
// delay domain tap and lock state types
// *************************************

`include "delay_cfg.svh"

package delay_pkg;

  // one lane's tap value
  typedef logic [`DELAY_TAP_WIDTH-1:0] tap_t;

  // stages in each lane's delay line, one per tap value
  localparam int DELAY_LINE_DEPTH = 1 << `DELAY_TAP_WIDTH;

  // delay controller states
  //   RESET  - held while delay_rst is high
  //   CALIB  - calibration timer running
  //   LOCKED - calibration complete
  typedef enum logic [1:0] {
    RESET  = 2'd0,
    CALIB  = 2'd1,
    LOCKED = 2'd2
  } lock_state_t;

endpackage

// ==== hdl/up_bus_pkg.sv ====
// *************************************
// processor bus types and address fields
// *************************************

package up_bus_pkg;

  // bus widths
  localparam int UP_ADDR_WIDTH = 14;
  localparam int UP_DATA_WIDTH = 32;

  // address fields, block select on top and lane below
  localparam int UP_BLK_HI  = 13;
  localparam int UP_BLK_LO  = 8;
  localparam int UP_LANE_HI = 7;
  localparam int UP_LANE_LO = 0;
  localparam int UP_LANE_W  = UP_LANE_HI - UP_LANE_LO + 1;

  typedef logic [UP_ADDR_WIDTH-1:0] up_addr_t;
  typedef logic [UP_DATA_WIDTH-1:0] up_data_t;

  // read value while the delay controller is not locked
  localparam up_data_t UP_RDATA_UNLOCKED = '1;

endpackage

// ==== hdl/delay_cfg.svh ====
// *************************************
// delay subsystem configuration macros
// *************************************

`ifndef DELAY_CFG_SVH
`define DELAY_CFG_SVH

// number of data lanes with a delay tap
`define DELAY_LANES 8

// bits in one tap, also sets the delay line depth
`define DELAY_TAP_WIDTH 5

// block select, compared against address bits 13 to 8
`define DELAY_BASE_ADDR 6'h02

// tap loaded into every lane once lock is seen
`define DELAY_INIT_TAP 5'd12

// delay_clk cycles spent calibrating before lock
`define DELAY_CALIB_CYCLES 40

`endif
